/* husky_top.f */
+incdir+source
source/husky_pkg.sv
source/usb_reg_frontend.sv
source/reg_system.sv
source/reg_trigger.sv
source/reg_target_io.sv
source/husky_top.sv
tb/tb_husky_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_husky_top -f husky_top.f || exit 1
./obj_dir/Vtb_husky_top > sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* source/husky_defines.svh */
`ifndef HUSKY_DEFINES_SVH
`define HUSKY_DEFINES_SVH

// Bus widths
`define HUSKY_DATA_W            8
`define HUSKY_ADDR_W            8
`define HUSKY_BYTECNT_W         7

`define HUSKY_ID_VALUE          8'h5A

// System block
`define HUSKY_ADDR_ID           8'h00
`define HUSKY_ADDR_SCRATCH      8'h01
`define HUSKY_ADDR_STATUS       8'h02
`define HUSKY_ADDR_CONTROL      8'h03

// Trigger block
`define HUSKY_ADDR_TRIG_MASK    8'h10
`define HUSKY_ADDR_TRIG_MODE    8'h11
`define HUSKY_ADDR_TRIG_COUNT   8'h12

// Target-IO block
`define HUSKY_ADDR_TARGET_POWER 8'h20
`define HUSKY_ADDR_TARGET_PROG  8'h21

// Heartbeat bit for the error LED, short for simulation
`define HUSKY_BLINK_BIT         3

`endif

/* source/husky_pkg.sv */
`default_nettype none

package husky_pkg;

   // Block chosen by the upper address nibble
   typedef enum logic [1:0] {
      BLK_SYSTEM  = 2'd0,
      BLK_TRIGGER = 2'd1,
      BLK_TARGET  = 2'd2,
      BLK_NONE    = 2'd3
   } reg_block_e;

   typedef enum logic {
      TRIG_OR  = 1'b0,
      TRIG_AND = 1'b1
   } trig_mode_e;

   typedef enum logic [1:0] {
      BUS_IDLE  = 2'd0,
      BUS_ADDR  = 2'd1,
      BUS_WRITE = 2'd2,
      BUS_READ  = 2'd3
   } bus_state_e;

endpackage

`default_nettype wire

/* source/husky_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "husky_defines.svh"

module husky_top (
   input  logic                     clk_usb_buf,
   input  logic                     reset_i,
   input  logic                     usb_cen_i,
   input  logic                     usb_alen_i,
   input  logic                     usb_wrn_i,
   input  logic                     usb_rdn_i,
   input  logic [`HUSKY_ADDR_W-1:0] usb_addr_i,
   input  logic [`HUSKY_DATA_W-1:0] usb_data_i,
   output logic [`HUSKY_DATA_W-1:0] usb_data_o,
   output logic                     usb_data_oe_o,
   input  logic [3:0]               target_io_i,
   input  logic                     sam_mosi_i,
   input  logic                     sam_spck_i,
   input  logic                     target_miso_i,
   output logic                     sam_miso_o,
   output logic                     target_poweron_o,
   output logic                     target_nrst_o,
   output logic                     target_nrst_oe_o,
   output logic                     target_mosi_o,
   output logic                     target_mosi_oe_o,
   output logic                     target_sck_o,
   output logic                     target_sck_oe_o,
   output logic                     trigger_o,
   output logic                     led_error_o
);

   husky_pkg::reg_block_e        reg_block;
   logic [`HUSKY_ADDR_W-1:0]     reg_addr;
   logic [`HUSKY_BYTECNT_W-1:0]  reg_bytecnt;
   logic [`HUSKY_DATA_W-1:0]     reg_wdata;
   logic                         reg_write;
   logic                         reg_read;
   logic                         bus_error;
   logic                         blk_rst;
   logic [`HUSKY_DATA_W-1:0]     rdata_system;
   logic [`HUSKY_DATA_W-1:0]     rdata_trigger;
   logic [`HUSKY_DATA_W-1:0]     rdata_target;

   usb_reg_frontend u_usb_reg_frontend (
      .clk_usb_buf     (clk_usb_buf),
      .reset_i         (reset_i),
      .usb_cen_i       (usb_cen_i),
      .usb_alen_i      (usb_alen_i),
      .usb_wrn_i       (usb_wrn_i),
      .usb_rdn_i       (usb_rdn_i),
      .usb_addr_i      (usb_addr_i),
      .usb_data_i      (usb_data_i),
      .usb_data_o      (usb_data_o),
      .usb_data_oe_o   (usb_data_oe_o),
      .reg_block_o     (reg_block),
      .reg_addr_o      (reg_addr),
      .reg_bytecnt_o   (reg_bytecnt),
      .reg_wdata_o     (reg_wdata),
      .reg_write_o     (reg_write),
      .reg_read_o      (reg_read),
      .bus_error_o     (bus_error),
      .rdata_system_i  (rdata_system),
      .rdata_trigger_i (rdata_trigger),
      .rdata_target_i  (rdata_target)
   );

   reg_system u_reg_system (
      .clk_usb_buf     (clk_usb_buf),
      .reset_i         (reset_i),
      .reg_block_i     (reg_block),
      .reg_addr_i      (reg_addr),
      .reg_wdata_i     (reg_wdata),
      .reg_write_i     (reg_write),
      .reg_read_i      (reg_read),
      .bus_error_i     (bus_error),
      .rdata_o         (rdata_system),
      .blk_rst_o       (blk_rst),
      .led_error_o     (led_error_o)
   );

   reg_trigger u_reg_trigger (
      .clk_usb_buf     (clk_usb_buf),
      .reset_i         (reset_i),
      .blk_rst_i       (blk_rst),
      .reg_block_i     (reg_block),
      .reg_addr_i      (reg_addr),
      .reg_bytecnt_i   (reg_bytecnt),
      .reg_wdata_i     (reg_wdata),
      .reg_write_i     (reg_write),
      .target_io_i     (target_io_i),
      .rdata_o         (rdata_trigger),
      .trigger_o       (trigger_o)
   );

   reg_target_io u_reg_target_io (
      .clk_usb_buf      (clk_usb_buf),
      .reset_i          (reset_i),
      .blk_rst_i        (blk_rst),
      .reg_block_i      (reg_block),
      .reg_addr_i       (reg_addr),
      .reg_wdata_i      (reg_wdata),
      .reg_write_i      (reg_write),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .rdata_o          (rdata_target),
      .target_poweron_o (target_poweron_o),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_mosi_oe_o (target_mosi_oe_o),
      .target_sck_o     (target_sck_o),
      .target_sck_oe_o  (target_sck_oe_o),
      .sam_miso_o       (sam_miso_o)
   );

endmodule

`default_nettype wire

/* source/reg_system.sv */
`timescale 1ns/100ps
`default_nettype none
`include "husky_defines.svh"

module reg_system (
   input  logic                     clk_usb_buf,
   input  logic                     reset_i,
   input  husky_pkg::reg_block_e    reg_block_i,
   input  logic [`HUSKY_ADDR_W-1:0] reg_addr_i,
   input  logic [`HUSKY_DATA_W-1:0] reg_wdata_i,
   input  logic                     reg_write_i,
   input  logic                     reg_read_i,
   input  logic                     bus_error_i,
   output logic [`HUSKY_DATA_W-1:0] rdata_o,
   output logic                     blk_rst_o,
   output logic                     led_error_o
);

   logic [`HUSKY_DATA_W-1:0]   scratch_q;
   logic                       error_q;
   logic [`HUSKY_BLINK_BIT:0]  heartbeat_q;
   logic                       sel;
   logic                       wr;

   assign sel = (reg_block_i == husky_pkg::BLK_SYSTEM);
   assign wr  = sel & reg_write_i;

   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         scratch_q   <= '0;
         error_q     <= 1'b0;
         blk_rst_o   <= 1'b0;
         heartbeat_q <= '0;
      end else begin
         heartbeat_q <= heartbeat_q + 1'b1;
         blk_rst_o   <= wr && (reg_addr_i[3:0] == 4'(`HUSKY_ADDR_CONTROL)) && reg_wdata_i[0];

         if (wr && reg_addr_i[3:0] == 4'(`HUSKY_ADDR_SCRATCH))
            scratch_q <= reg_wdata_i;

         // A new error wins over a clear in the same cycle
         if (bus_error_i)
            error_q <= 1'b1;
         else if (wr && reg_addr_i[3:0] == 4'(`HUSKY_ADDR_STATUS) && reg_wdata_i[0])
            error_q <= 1'b0;
      end
   end

   // Flash while the sticky flag is set
   assign led_error_o = error_q & heartbeat_q[`HUSKY_BLINK_BIT];

   always_comb begin
      rdata_o = '0;
      if (sel && reg_read_i) begin
         case (reg_addr_i[3:0])
            4'(`HUSKY_ADDR_ID):      rdata_o = `HUSKY_ID_VALUE;
            4'(`HUSKY_ADDR_SCRATCH): rdata_o = scratch_q;
            4'(`HUSKY_ADDR_STATUS):  rdata_o = {{(`HUSKY_DATA_W-1){1'b0}}, error_q};
            default:                 rdata_o = '0;   // CONTROL reads back zero
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/reg_target_io.sv */
`timescale 1ns/100ps
`default_nettype none
`include "husky_defines.svh"

module reg_target_io (
   input  logic                     clk_usb_buf,
   input  logic                     reset_i,
   input  logic                     blk_rst_i,
   input  husky_pkg::reg_block_e    reg_block_i,
   input  logic [`HUSKY_ADDR_W-1:0] reg_addr_i,
   input  logic [`HUSKY_DATA_W-1:0] reg_wdata_i,
   input  logic                     reg_write_i,
   input  logic                     sam_mosi_i,
   input  logic                     sam_spck_i,
   input  logic                     target_miso_i,
   output logic [`HUSKY_DATA_W-1:0] rdata_o,
   output logic                     target_poweron_o,
   output logic                     target_nrst_o,
   output logic                     target_nrst_oe_o,
   output logic                     target_mosi_o,
   output logic                     target_mosi_oe_o,
   output logic                     target_sck_o,
   output logic                     target_sck_oe_o,
   output logic                     sam_miso_o
);

   logic power_q;
   logic prog_en_q;
   logic rst_ovr_en_q;
   logic rst_ovr_val_q;
   logic sel;
   logic prog_active;

   assign sel = (reg_block_i == husky_pkg::BLK_TARGET);

   always_ff @(posedge clk_usb_buf) begin
      if (reset_i || blk_rst_i) begin
         power_q       <= 1'b0;
         prog_en_q     <= 1'b0;
         rst_ovr_en_q  <= 1'b0;
         rst_ovr_val_q <= 1'b0;
      end else if (sel && reg_write_i) begin
         if (reg_addr_i[3:0] == 4'(`HUSKY_ADDR_TARGET_POWER))
            power_q <= reg_wdata_i[0];
         if (reg_addr_i[3:0] == 4'(`HUSKY_ADDR_TARGET_PROG)) begin
            prog_en_q     <= reg_wdata_i[0];
            rst_ovr_en_q  <= reg_wdata_i[1];
            rst_ovr_val_q <= reg_wdata_i[2];
         end
      end
   end

   // Pins float whenever the target is unpowered
   assign prog_active      = power_q & prog_en_q;
   assign target_poweron_o = power_q;

   assign target_nrst_oe_o = power_q & (prog_en_q | rst_ovr_en_q);
   assign target_nrst_o    = ~prog_en_q & rst_ovr_val_q;   // Held low while programming

   assign target_mosi_oe_o = prog_active;
   assign target_mosi_o    = prog_active & sam_mosi_i;
   assign target_sck_oe_o  = prog_active;
   assign target_sck_o     = prog_active & sam_spck_i;
   assign sam_miso_o       = prog_active & target_miso_i;

   always_comb begin
      rdata_o = '0;
      if (sel) begin
         case (reg_addr_i[3:0])
            4'(`HUSKY_ADDR_TARGET_POWER): rdata_o = {7'b0, power_q};
            4'(`HUSKY_ADDR_TARGET_PROG):
               rdata_o = {5'b0, rst_ovr_val_q, rst_ovr_en_q, prog_en_q};
            default: rdata_o = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/reg_trigger.sv */
`timescale 1ns/100ps
`default_nettype none
`include "husky_defines.svh"

module reg_trigger (
   input  logic                        clk_usb_buf,
   input  logic                        reset_i,
   input  logic                        blk_rst_i,
   input  husky_pkg::reg_block_e       reg_block_i,
   input  logic [`HUSKY_ADDR_W-1:0]    reg_addr_i,
   input  logic [`HUSKY_BYTECNT_W-1:0] reg_bytecnt_i,
   input  logic [`HUSKY_DATA_W-1:0]    reg_wdata_i,
   input  logic                        reg_write_i,
   input  logic [3:0]                  target_io_i,
   output logic [`HUSKY_DATA_W-1:0]    rdata_o,
   output logic                        trigger_o
);

   logic [3:0]             io_meta;
   logic [3:0]             io_sync;
   logic [3:0]             mask_q;
   husky_pkg::trig_mode_e  mode_q;
   logic [15:0]            count_q;
   logic                   trig_d;
   logic [3:0]             masked;
   logic                   trig_comb;
   logic                   trig_rise;
   logic                   sel;
   logic                   count_wr;

   assign sel       = (reg_block_i == husky_pkg::BLK_TRIGGER);
   assign count_wr  = sel && reg_write_i && (reg_addr_i[3:0] == 4'(`HUSKY_ADDR_TRIG_COUNT));
   assign masked    = io_sync & mask_q;
   assign trig_rise = trigger_o & ~trig_d;

   // An empty mask never fires in AND mode
   assign trig_comb = (mode_q == husky_pkg::TRIG_OR) ? |masked :
                      ((mask_q != 4'b0) && (masked == mask_q));

   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         io_meta <= '0;
         io_sync <= '0;
      end else begin
         io_meta <= target_io_i;   // Pins are asynchronous to the USB clock
         io_sync <= io_meta;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (reset_i || blk_rst_i) begin
         mask_q    <= '0;
         mode_q    <= husky_pkg::TRIG_OR;
         count_q   <= '0;
         trigger_o <= 1'b0;
         trig_d    <= 1'b0;
      end else begin
         trigger_o <= trig_comb;
         trig_d    <= trigger_o;

         if (count_wr)
            count_q <= '0;   // Any data clears the count
         else if (trig_rise)
            count_q <= count_q + 1'b1;

         if (sel && reg_write_i) begin
            if (reg_addr_i[3:0] == 4'(`HUSKY_ADDR_TRIG_MASK))
               mask_q <= reg_wdata_i[3:0];
            if (reg_addr_i[3:0] == 4'(`HUSKY_ADDR_TRIG_MODE))
               mode_q <= husky_pkg::trig_mode_e'(reg_wdata_i[0]);
         end
      end
   end

   always_comb begin
      rdata_o = '0;
      if (sel) begin
         case (reg_addr_i[3:0])
            4'(`HUSKY_ADDR_TRIG_MASK): rdata_o = {4'b0, mask_q};
            4'(`HUSKY_ADDR_TRIG_MODE): rdata_o = {7'b0, mode_q};
            4'(`HUSKY_ADDR_TRIG_COUNT): begin
               if (reg_bytecnt_i == '0)
                  rdata_o = count_q[7:0];
               else if (reg_bytecnt_i == 1)
                  rdata_o = count_q[15:8];
            end
            default: rdata_o = '0;
         endcase
      end
   end

   a_count_clear_vs_edge: assert property (@(posedge clk_usb_buf) disable iff (reset_i)
      count_wr |-> !trig_rise);

endmodule

`default_nettype wire

/* source/usb_reg_frontend.sv */
`timescale 1ns/100ps
`default_nettype none
`include "husky_defines.svh"

module usb_reg_frontend (
   input  logic                        clk_usb_buf,
   input  logic                        reset_i,
   input  logic                        usb_cen_i,
   input  logic                        usb_alen_i,
   input  logic                        usb_wrn_i,
   input  logic                        usb_rdn_i,
   input  logic [`HUSKY_ADDR_W-1:0]    usb_addr_i,
   input  logic [`HUSKY_DATA_W-1:0]    usb_data_i,
   output logic [`HUSKY_DATA_W-1:0]    usb_data_o,
   output logic                        usb_data_oe_o,
   output husky_pkg::reg_block_e       reg_block_o,
   output logic [`HUSKY_ADDR_W-1:0]    reg_addr_o,
   output logic [`HUSKY_BYTECNT_W-1:0] reg_bytecnt_o,
   output logic [`HUSKY_DATA_W-1:0]    reg_wdata_o,
   output logic                        reg_write_o,
   output logic                        reg_read_o,
   output logic                        bus_error_o,
   input  logic [`HUSKY_DATA_W-1:0]    rdata_system_i,
   input  logic [`HUSKY_DATA_W-1:0]    rdata_trigger_i,
   input  logic [`HUSKY_DATA_W-1:0]    rdata_target_i
);

   husky_pkg::bus_state_e state;
   husky_pkg::reg_block_e block_dec;
   logic [`HUSKY_BYTECNT_W-1:0] bytecnt_q;
   logic ale_stb;
   logic wr_stb;
   logic rd_stb;
   logic idle;
   logic mapped;

   // Strobes only count while the chip is enabled
   assign ale_stb = ~usb_cen_i & ~usb_alen_i;
   assign wr_stb  = ~usb_cen_i & ~usb_wrn_i;
   assign rd_stb  = ~usb_cen_i & ~usb_rdn_i;
   assign idle    = (state == husky_pkg::BUS_IDLE);
   assign mapped  = (reg_block_o != husky_pkg::BLK_NONE);

   assign reg_bytecnt_o = bytecnt_q;

   always_comb begin
      case (usb_addr_i[`HUSKY_ADDR_W-1 -: 4])
         4'h0:    block_dec = husky_pkg::BLK_SYSTEM;
         4'h1:    block_dec = husky_pkg::BLK_TRIGGER;
         4'h2:    block_dec = husky_pkg::BLK_TARGET;
         default: block_dec = husky_pkg::BLK_NONE;
      endcase
   end

   always_ff @(posedge clk_usb_buf) begin
      if (reset_i) begin
         state         <= husky_pkg::BUS_IDLE;
         reg_block_o   <= husky_pkg::BLK_NONE;
         bytecnt_q     <= '0;
         reg_write_o   <= 1'b0;
         reg_read_o    <= 1'b0;
         bus_error_o   <= 1'b0;
         usb_data_oe_o <= 1'b0;
      end else begin
         state       <= husky_pkg::BUS_IDLE;
         reg_write_o <= 1'b0;
         reg_read_o  <= 1'b0;
         bus_error_o <= 1'b0;

         // Count advances once the pulse has been served
         if (state == husky_pkg::BUS_WRITE || state == husky_pkg::BUS_READ)
            bytecnt_q <= bytecnt_q + 1'b1;

         if (idle) begin
            if (ale_stb) begin
               state       <= husky_pkg::BUS_ADDR;
               reg_block_o <= block_dec;
               bytecnt_q   <= '0;
            end else if (wr_stb) begin
               state       <= husky_pkg::BUS_WRITE;
               reg_write_o <= mapped;
               bus_error_o <= ~mapped;
            end else if (rd_stb) begin
               state       <= husky_pkg::BUS_READ;
               reg_read_o  <= mapped;
               bus_error_o <= ~mapped;
            end
         end

         if (usb_cen_i)
            usb_data_oe_o <= 1'b0;   // Release the bus when deselected
         else if (state == husky_pkg::BUS_READ)
            usb_data_oe_o <= 1'b1;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (idle && ale_stb)
         reg_addr_o <= usb_addr_i;
      if (idle && wr_stb)
         reg_wdata_o <= usb_data_i;
      // Unselected blocks return zero
      if (state == husky_pkg::BUS_READ)
         usb_data_o <= rdata_system_i | rdata_trigger_i | rdata_target_i;
   end

   a_no_rd_wr_overlap: assert property (@(posedge clk_usb_buf) disable iff (reset_i)
      !(reg_read_o && reg_write_o));

   // Latched address must sit in one of the three block ranges
   a_pulse_mapped: assert property (@(posedge clk_usb_buf) disable iff (reset_i)
      (reg_read_o || reg_write_o) |-> (reg_addr_o[`HUSKY_ADDR_W-1 -: 4] <= 4'h2));

endmodule

`default_nettype wire

/* tb/husky_trace.txt */
// Records op_aa_bb_cc in hex. 01 write aa<=bb, 02 read aa expect bb, 03 read aa as two bytes
// expect bb low cc high, 04 pins io=aa bb={mosi,spck,miso}, 05 expect target pins
// aa={pwr,nrst,nrst_oe,mosi,mosi_oe,sck,sck_oe,miso}, 06 wait trigger_o==aa,
// 07 after 4 cycles expect aa={led,data_oe,trigger}, 08 led blinks if aa, ff end
// After reset
02_00_5a_00 05_00_00_00 07_00_00_00 02_02_00_00
// Scratch and bus error
01_01_a5_00 02_01_a5_00 01_01_3c_00 02_01_3c_00
01_40_77_00 02_02_01_00 08_01_00_00
01_02_01_00 02_02_00_00 08_00_00_00
// OR mode with mask 0101
01_10_05_00 01_11_00_00 02_10_05_00 01_12_00_00
04_01_00_00 06_01_00_00 04_00_00_00 06_00_00_00
04_04_00_00 06_01_00_00 04_00_00_00 06_00_00_00
04_02_00_00 07_00_00_00 04_00_00_00
// AND mode needs both lines
01_11_01_00 02_11_01_00 04_01_00_00 07_00_00_00
04_05_00_00 06_01_00_00 04_0f_00_00 07_01_00_00
04_00_00_00 06_00_00_00 04_05_00_00 06_01_00_00
04_04_00_00 06_00_00_00 03_12_04_00
// Programming pass-through
01_20_01_00 05_80_00_00 01_21_01_00 05_aa_00_00
04_00_04_00 05_ba_00_00 04_00_03_00 05_af_00_00 04_00_00_00
// Reset override and power off
01_21_06_00 05_e0_00_00 04_00_07_00 05_e0_00_00
01_21_02_00 05_a0_00_00 01_21_00_00 05_80_00_00
01_21_01_00 05_bf_00_00 01_20_00_00 05_00_00_00 04_00_00_00
// Soft reset keeps scratch
01_20_01_00 01_10_0a_00 04_0a_00_00 06_01_00_00
04_00_00_00 06_00_00_00 03_12_05_00 01_01_c3_00
01_03_01_00 02_10_00_00 02_11_00_00 03_12_00_00
02_20_00_00 02_01_c3_00 05_00_00_00
ff_00_00_00

/* tb/tb_husky_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "husky_defines.svh"

module tb_husky_top;

   localparam int TRACE_DEPTH = 128;

   logic        clk_usb_buf = 1'b0;
   logic        reset_i;
   logic        usb_cen_i;
   logic        usb_alen_i;
   logic        usb_wrn_i;
   logic        usb_rdn_i;
   logic [7:0]  usb_addr_i;
   logic [7:0]  usb_data_i;
   logic [7:0]  usb_data_o;
   logic        usb_data_oe_o;
   logic [3:0]  target_io_i;
   logic        sam_mosi_i;
   logic        sam_spck_i;
   logic        target_miso_i;
   logic        sam_miso_o;
   logic        target_poweron_o;
   logic        target_nrst_o;
   logic        target_nrst_oe_o;
   logic        target_mosi_o;
   logic        target_mosi_oe_o;
   logic        target_sck_o;
   logic        target_sck_oe_o;
   logic        trigger_o;
   logic        led_error_o;

   logic [31:0] trace [0:TRACE_DEPTH-1];   // op, a, b, c
   logic [15:0] edge_count;
   logic [15:0] edge_base;
   logic        trig_seen;
   int          idx;
   husky_pkg::trig_mode_e cur_mode;

   husky_top u_husky_top (
      .clk_usb_buf      (clk_usb_buf),
      .reset_i          (reset_i),
      .usb_cen_i        (usb_cen_i),
      .usb_alen_i       (usb_alen_i),
      .usb_wrn_i        (usb_wrn_i),
      .usb_rdn_i        (usb_rdn_i),
      .usb_addr_i       (usb_addr_i),
      .usb_data_i       (usb_data_i),
      .usb_data_o       (usb_data_o),
      .usb_data_oe_o    (usb_data_oe_o),
      .target_io_i      (target_io_i),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .sam_miso_o       (sam_miso_o),
      .target_poweron_o (target_poweron_o),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_mosi_oe_o (target_mosi_oe_o),
      .target_sck_o     (target_sck_o),
      .target_sck_oe_o  (target_sck_oe_o),
      .trigger_o        (trigger_o),
      .led_error_o      (led_error_o)
   );

   always #4 clk_usb_buf = ~clk_usb_buf;   // 8 ns period

   // Independent count of trigger_o rising edges
   always @(negedge clk_usb_buf) begin
      if (reset_i) begin
         edge_count <= '0;
         trig_seen  <= 1'b0;
      end else begin
         if (trigger_o && !trig_seen)
            edge_count <= edge_count + 1'b1;
         trig_seen <= trigger_o;
      end
   end

   task automatic abort_run(input string reason);
      $display("error at %0t ns: %s", $time, reason);
      $display("Some tests failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_val(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
      if (actual !== expected) begin
         $display("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                  $time, name, actual, expected);
         $display("Some tests failed");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic latch_addr(input logic [7:0] addr);
      @(posedge clk_usb_buf);
      usb_cen_i  <= 1'b0;
      usb_alen_i <= 1'b0;
      usb_addr_i <= addr;
      @(posedge clk_usb_buf);
      usb_cen_i  <= 1'b1;
      usb_alen_i <= 1'b1;
      repeat (3) @(posedge clk_usb_buf);   // Minimum gap between strobes
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      latch_addr(addr);
      @(posedge clk_usb_buf);
      usb_cen_i  <= 1'b0;
      usb_wrn_i  <= 1'b0;
      usb_data_i <= data;
      @(posedge clk_usb_buf);
      usb_cen_i <= 1'b1;
      usb_wrn_i <= 1'b1;
      repeat (3) @(posedge clk_usb_buf);
      // Track what the count and mode should now be
      if (addr == `HUSKY_ADDR_TRIG_COUNT)
         edge_base = edge_count;
      if (addr == `HUSKY_ADDR_TRIG_MODE)
         cur_mode = husky_pkg::trig_mode_e'(data[0]);
      if (addr == `HUSKY_ADDR_CONTROL && data[0]) begin
         edge_base = edge_count;
         cur_mode  = husky_pkg::TRIG_OR;
      end
   endtask

   task automatic read_byte(output logic [7:0] data);
      int n;
      n = 0;
      @(posedge clk_usb_buf);
      usb_cen_i <= 1'b0;
      usb_rdn_i <= 1'b0;
      @(posedge clk_usb_buf);
      usb_rdn_i <= 1'b1;   // CEn stays low until the data is driven
      @(negedge clk_usb_buf);
      while (usb_data_oe_o !== 1'b1) begin
         if (n == 8)
            abort_run("usb_data_oe_o never rose after a read strobe");
         n++;
         @(negedge clk_usb_buf);
      end
      data = usb_data_o;
      @(posedge clk_usb_buf);
      usb_cen_i <= 1'b1;
      repeat (3) @(posedge clk_usb_buf);
   endtask

   task automatic wait_trigger(input logic level);
      int n;
      n = 0;
      @(negedge clk_usb_buf);
      while (trigger_o !== level) begin
         if (n == 16)
            abort_run("trigger_o did not reach the expected level");
         n++;
         @(negedge clk_usb_buf);
      end
   endtask

   task automatic check_blink(input logic expect_blink);
      int n;
      n = 0;
      if (expect_blink) begin
         @(negedge clk_usb_buf);
         while (led_error_o !== 1'b1) begin
            if (n == 32)
               abort_run("led_error_o did not turn on with the error flag set");
            n++;
            @(negedge clk_usb_buf);
         end
         n = 0;
         while (led_error_o !== 1'b0) begin
            if (n == 32)
               abort_run("led_error_o did not turn off again while blinking");
            n++;
            @(negedge clk_usb_buf);
         end
      end else begin
         repeat (32) begin
            @(negedge clk_usb_buf);
            compare_val("led_error_o", 16'(led_error_o), 16'h0);
         end
      end
   endtask

   task automatic run_op(input logic [31:0] rec);
      logic [7:0] op;
      logic [7:0] a;
      logic [7:0] b;
      logic [7:0] c;
      logic [7:0] lo;
      logic [7:0] hi;
      op = rec[31:24];
      a  = rec[23:16];
      b  = rec[15:8];
      c  = rec[7:0];
      case (op)
         8'h01: bus_write(a, b);
         8'h02: begin
            latch_addr(a);
            read_byte(lo);
            compare_val($sformatf("usb_data_o from 0x%02h", a), 16'(lo), 16'(b));
         end
         8'h03: begin   // Two-byte count read, low byte first
            latch_addr(a);
            read_byte(lo);
            read_byte(hi);
            compare_val("trig count low byte", 16'(lo), 16'(b));
            compare_val("trig count high byte", 16'(hi), 16'(c));
            compare_val("trig count vs trigger_o edges", {hi, lo}, edge_count - edge_base);
         end
         8'h04: begin
            @(posedge clk_usb_buf);
            target_io_i <= a[3:0];
            {sam_mosi_i, sam_spck_i, target_miso_i} <= b[2:0];
         end
         8'h05: begin
            @(negedge clk_usb_buf);
            compare_val("target_poweron_o", 16'(target_poweron_o), 16'(a[7]));
            compare_val("target_nrst_o", 16'(target_nrst_o), 16'(a[6]));
            compare_val("target_nrst_oe_o", 16'(target_nrst_oe_o), 16'(a[5]));
            compare_val("target_mosi_o", 16'(target_mosi_o), 16'(a[4]));
            compare_val("target_mosi_oe_o", 16'(target_mosi_oe_o), 16'(a[3]));
            compare_val("target_sck_o", 16'(target_sck_o), 16'(a[2]));
            compare_val("target_sck_oe_o", 16'(target_sck_oe_o), 16'(a[1]));
            compare_val("sam_miso_o", 16'(sam_miso_o), 16'(a[0]));
         end
         8'h06: wait_trigger(a[0]);
         8'h07: begin
            repeat (4) @(negedge clk_usb_buf);   // Covers the 3-cycle trigger path
            compare_val((cur_mode == husky_pkg::TRIG_AND) ? "trigger_o in AND mode" :
                        "trigger_o in OR mode", 16'(trigger_o), 16'(a[0]));
            compare_val("usb_data_oe_o", 16'(usb_data_oe_o), 16'(a[1]));
            compare_val("led_error_o", 16'(led_error_o), 16'(a[2]));
         end
         8'h08: check_blink(a[0]);
         default: abort_run($sformatf("unknown trace opcode 0x%02h", op));
      endcase
   endtask

   initial begin
      reset_i       = 1'b1;
      usb_cen_i     = 1'b1;
      usb_alen_i    = 1'b1;
      usb_wrn_i     = 1'b1;
      usb_rdn_i     = 1'b1;
      usb_addr_i    = '0;
      usb_data_i    = '0;
      target_io_i   = '0;
      sam_mosi_i    = 1'b0;
      sam_spck_i    = 1'b0;
      target_miso_i = 1'b0;
      edge_base     = '0;
      cur_mode      = husky_pkg::TRIG_OR;
      $readmemh("tb/husky_trace.txt", trace);

      repeat (2) @(posedge clk_usb_buf);
      reset_i <= 1'b0;
      @(posedge clk_usb_buf);

      idx = 0;
      while (idx < TRACE_DEPTH && trace[idx][31:24] !== 8'hff) begin
         run_op(trace[idx]);
         idx++;
      end
      if (idx == TRACE_DEPTH)
         abort_run("trace has no end record");

      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire
